/* sources.f */
common/mac_cfg_pkg.sv
common/mac_cfg_cmd_if.sv
common/mac_cfg_bus_if.sv
mac_cfg/mac_cfg_if.sv
mac_cfg/mac_cfg_init.sv
verilog/mac_csr.sv
verilog/mac_cfg_top.sv
verification/mac_cfg_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= mac_cfg_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/mac_cfg_tb.sv */
module mac_cfg_tb import mac_cfg_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 3000;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          host_wr;
    logic          host_rd;
    cfg_addr_t     host_addr;
    cfg_data_t     host_wdata;
    logic          host_rdy;
    cfg_data_t     host_rdata;
    logic          host_rdata_vld;
    logic          init_done;
    logic          init_error;
    station_addr_t station_addr;
    frame_len_t    max_frame_len;
    logic          tx_ena;
    logic          rx_ena;
    logic          promisc;

    logic [31:0] lfsr = 32'h216c;
    cfg_data_t   model [0:255];  // expected register contents.
    int          check_cnt    = 0;
    int          mismatch_cnt = 0;
    int          fail_cnt     = 0;
    int          cycle_cnt    = 0;

    mac_cfg_top UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;  // taps 32, 22, 2, 1.
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output cfg_data_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_data(input string name, input cfg_data_t exp, input cfg_data_t act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_station(input string name, input station_addr_t exp,
                                 input station_addr_t act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input frame_len_t exp, input frame_len_t act);
        check_cnt++;
        if (act !== exp) begin
            mismatch_cnt++;
            $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        check_cnt++;
        if (act != exp) begin
            mismatch_cnt++;
            $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic void model_write(input cfg_addr_t addr, input cfg_data_t data);
        case (addr)
            REG_COMMAND, REG_MAC_0, REG_SCRATCH:        model[addr] = data;
            REG_MAC_1, REG_FRM_LENGTH, REG_PAUSE_QUANT: model[addr] = {16'h0000, data[15:0]};
            default: ;  // revision and holes keep their value.
        endcase
    endfunction

    function automatic cfg_data_t model_read(input cfg_addr_t addr);
        if (addr == REG_REV) begin
            return MAC_REV;
        end
        return model[addr];
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < 256; i++) begin
            model[i] = '0;
        end
        model_write(REG_COMMAND, INIT_COMMAND);
        model_write(REG_MAC_0, INIT_STATION_ADDR[31:0]);
        model_write(REG_MAC_1, {16'h0000, INIT_STATION_ADDR[47:32]});
        model_write(REG_FRM_LENGTH, {16'h0000, INIT_FRAME_LEN});
    endfunction

    task automatic wait_ready();
        while (!host_rdy) begin
            @(negedge clk);
        end
    endtask

    task automatic host_write(input cfg_addr_t addr, input cfg_data_t data);
        wait_ready();
        @(posedge clk);
        host_wr    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge clk);
        host_wr <= 1'b0;
        @(negedge clk);
        wait_ready();  // back once the strobe has dropped.
    endtask

    task automatic host_read(input cfg_addr_t addr, output cfg_data_t data, output int cycles);
        wait_ready();
        @(posedge clk);
        host_rd   <= 1'b1;
        host_addr <= addr;
        @(posedge clk);  // pulse sampled here.
        host_rd <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!host_rdata_vld) begin
            if (host_rdy) begin
                fail_cnt++;
                $display("host_rdy went high before the read of address %h returned", addr);
            end
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        data = host_rdata;
    endtask

    task automatic read_expect(input string name, input cfg_addr_t addr, input cfg_data_t exp);
        cfg_data_t data;
        int        cycles;
        host_read(addr, data, cycles);
        check_data(name, exp, data);
    endtask

    task automatic boot_sequence();
        @(negedge clk);
        while (!init_done && !init_error) begin
            if (host_rdy) begin
                fail_cnt++;
                $display("host_rdy is high before the boot sequence has finished");
            end
            @(negedge clk);
        end
        check_bit("boot init_done", 1'b1, init_done);
        check_bit("boot init_error", 1'b0, init_error);
        check_station("boot station_addr", INIT_STATION_ADDR, station_addr);
        check_len("boot max_frame_len", INIT_FRAME_LEN, max_frame_len);
        check_bit("boot tx_ena", 1'b1, tx_ena);
        check_bit("boot rx_ena", 1'b1, rx_ena);
        check_bit("boot promisc", 1'b0, promisc);
    endtask

    task automatic boot_readback();
        read_expect("readback command", REG_COMMAND, INIT_COMMAND);
        read_expect("readback mac_0", REG_MAC_0, INIT_STATION_ADDR[31:0]);
        read_expect("readback mac_1", REG_MAC_1, {16'h0000, INIT_STATION_ADDR[47:32]});
        read_expect("readback frame length", REG_FRM_LENGTH, {16'h0000, INIT_FRAME_LEN});
        read_expect("readback revision", REG_REV, MAC_REV);
    endtask

    task automatic read_latency();
        cfg_data_t data;
        int        cycles;
        host_read(REG_REV, data, cycles);
        check_data("latency read data", MAC_REV, data);
        check_count("latency cycles", CSR_WAIT + 2, cycles);
        @(negedge clk);
        check_bit("latency single vld pulse", 1'b0, host_rdata_vld);
    endtask

    task automatic random_scratch();
        cfg_addr_t addr;
        cfg_data_t wdata;
        cfg_data_t exp;
        for (int i = 0; i < 20; i++) begin
            addr = i[0] ? REG_PAUSE_QUANT : REG_SCRATCH;
            take_bits(32, wdata);
            exp = (addr == REG_SCRATCH) ? wdata : {16'h0000, wdata[15:0]};  // pause is 16 bits.
            host_write(addr, wdata);
            model_write(addr, wdata);
            read_expect($sformatf("random word %0d", i), addr, exp);
        end
    endtask

    task automatic protected_regs();
        cfg_data_t cmd_val;
        cfg_data_t junk;
        cmd_val = INIT_COMMAND;
        cmd_val[CMD_PROMISC_BIT] = 1'b1;
        cmd_val[CMD_TX_ENA_BIT]  = 1'b0;
        host_write(REG_COMMAND, cmd_val);
        model_write(REG_COMMAND, cmd_val);
        check_bit("command promisc", 1'b1, promisc);
        check_bit("command tx_ena", 1'b0, tx_ena);
        check_bit("command rx_ena", 1'b1, rx_ena);
        take_bits(32, junk);
        host_write(REG_REV, junk);
        read_expect("revision after write", REG_REV, MAC_REV);
        host_write(8'h01, junk);
        host_write(8'hc5, ~junk);
        read_expect("unmapped 0x01", 8'h01, 32'h0);
        read_expect("unmapped 0xc5", 8'hc5, 32'h0);
        read_expect("revision after unmapped write", REG_REV, MAC_REV);
    endtask

    task automatic back_to_back();
        cfg_addr_t addr_list [8];
        cfg_data_t bits;
        cfg_data_t wdata;
        cfg_addr_t addr;
        addr_list = '{REG_REV, 8'h01, REG_COMMAND, REG_MAC_0,
                      REG_MAC_1, REG_FRM_LENGTH, REG_PAUSE_QUANT, REG_SCRATCH};
        for (int i = 0; i < 24; i++) begin
            take_bits(4, bits);
            addr = addr_list[bits[2:0]];
            if (bits[3]) begin
                take_bits(32, wdata);
                host_write(addr, wdata);
                model_write(addr, wdata);
            end else begin
                read_expect($sformatf("back to back read %0d", i), addr, model_read(addr));
            end
        end
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d mismatches, %0d other errors",
                 check_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        fail_cnt++;
        $display("timeout waiting for DUT");
        finish_run();
    end

    initial begin
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        rst_n      = 1'b0;
        repeat (8) @(posedge clk);
        check_bit("reset host_rdy", 1'b0, host_rdy);
        check_bit("reset init_done", 1'b0, init_done);
        check_bit("reset tx_ena", 1'b0, tx_ena);
        check_bit("reset promisc", 1'b0, promisc);
        rst_n <= 1'b1;
        boot_sequence();
        model_reset();
        boot_readback();
        read_latency();
        random_scratch();
        protected_regs();
        back_to_back();
        finish_run();
    end

endmodule

/* verilog/mac_cfg_top.sv */
module mac_cfg_top import mac_cfg_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          host_wr,
    input  logic          host_rd,
    input  cfg_addr_t     host_addr,
    input  cfg_data_t     host_wdata,
    output logic          host_rdy,
    output cfg_data_t     host_rdata,
    output logic          host_rdata_vld,
    output logic          init_done,
    output logic          init_error,
    output station_addr_t station_addr,
    output frame_len_t    max_frame_len,
    output logic          tx_ena,
    output logic          rx_ena,
    output logic          promisc
);

    mac_cfg_cmd_if cmd_if ();
    mac_cfg_bus_if bus_if ();

    // boot sequencer, then host pass-through.
    mac_cfg_init u_init (
        .clk            (clk),
        .rst_n          (rst_n),
        .host_wr        (host_wr),
        .host_rd        (host_rd),
        .host_addr      (host_addr),
        .host_wdata     (host_wdata),
        .host_rdy       (host_rdy),
        .host_rdata     (host_rdata),
        .host_rdata_vld (host_rdata_vld),
        .init_done      (init_done),
        .init_error     (init_error),
        .cmd            (cmd_if.requester)
    );

    mac_cfg_if u_bridge (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd_if.bridge),
        .bus   (bus_if.master)
    );

    mac_csr u_csr (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (bus_if.slave),
        .station_addr  (station_addr),
        .max_frame_len (max_frame_len),
        .tx_ena        (tx_ena),
        .rx_ena        (rx_ena),
        .promisc       (promisc)
    );

endmodule

/* verilog/mac_csr.sv */
module mac_csr import mac_cfg_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    mac_cfg_bus_if.slave  bus,
    output station_addr_t station_addr,
    output frame_len_t    max_frame_len,
    output logic          tx_ena,
    output logic          rx_ena,
    output logic          promisc
);

    csr_state_t             state;
    logic [CSR_CNT_W-1:0]   wait_cnt;
    logic                   strobe;
    cfg_data_t              rd_val;

    cfg_data_t              command_reg;
    cfg_data_t              mac0_reg;
    logic [15:0]            mac1_reg;
    frame_len_t             frm_len_reg;
    logic [15:0]            pause_reg;
    cfg_data_t              scratch_reg;

    assign strobe = bus.mac_wr || bus.mac_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= CSR_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                CSR_IDLE: begin
                    wait_cnt <= '0;
                    if (strobe) state <= CSR_BUSY;
                end
                CSR_BUSY: begin
                    if (wait_cnt == CSR_CNT_W'(CSR_WAIT - 1)) begin
                        state <= CSR_DONE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                CSR_DONE: state <= CSR_HOLD;
                CSR_HOLD: if (!strobe) state <= CSR_IDLE;  // wait for the master to let go.
                default:  state <= CSR_IDLE;
            endcase
        end
    end

    assign bus.mac_wait = (state == CSR_BUSY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            command_reg <= '0;
            mac0_reg    <= '0;
            mac1_reg    <= '0;
            frm_len_reg <= '0;
            pause_reg   <= '0;
            scratch_reg <= '0;
        end else if (state == CSR_DONE && bus.mac_wr) begin
            case (bus.mac_addr)
                REG_COMMAND:     command_reg <= bus.mac_wdata;
                REG_MAC_0:       mac0_reg    <= bus.mac_wdata;
                REG_MAC_1:       mac1_reg    <= bus.mac_wdata[15:0];
                REG_FRM_LENGTH:  frm_len_reg <= bus.mac_wdata[15:0];
                REG_PAUSE_QUANT: pause_reg   <= bus.mac_wdata[15:0];
                REG_SCRATCH:     scratch_reg <= bus.mac_wdata;
                default: ;  // revision and holes are not writable.
            endcase
        end
    end

    always_comb begin
        case (bus.mac_addr)
            REG_REV:         rd_val = MAC_REV;
            REG_COMMAND:     rd_val = command_reg;
            REG_MAC_0:       rd_val = mac0_reg;
            REG_MAC_1:       rd_val = cfg_data_t'(mac1_reg);
            REG_FRM_LENGTH:  rd_val = cfg_data_t'(frm_len_reg);
            REG_PAUSE_QUANT: rd_val = cfg_data_t'(pause_reg);
            REG_SCRATCH:     rd_val = scratch_reg;
            default:         rd_val = '0;
        endcase
    end

    assign bus.mac_rdata = (state == CSR_DONE) ? rd_val : '0;

    assign station_addr  = {mac1_reg, mac0_reg};
    assign max_frame_len = frm_len_reg;
    assign tx_ena        = command_reg[CMD_TX_ENA_BIT];
    assign rx_ena        = command_reg[CMD_RX_ENA_BIT];
    assign promisc       = command_reg[CMD_PROMISC_BIT];

endmodule

/* mac_cfg/mac_cfg_init.sv */
module mac_cfg_init import mac_cfg_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             host_wr,
    input  logic             host_rd,
    input  cfg_addr_t        host_addr,
    input  cfg_data_t        host_wdata,
    output logic             host_rdy,
    output cfg_data_t        host_rdata,
    output logic             host_rdata_vld,
    output logic             init_done,
    output logic             init_error,
    mac_cfg_cmd_if.requester cmd
);

    init_state_t state;
    init_state_t state_next;

    logic      boot_wr;
    logic      boot_rd;
    cfg_addr_t boot_addr;
    cfg_data_t boot_wdata;

    logic      issue_wr;
    logic      issue_rd;
    cfg_addr_t next_addr;
    cfg_data_t next_wdata;
    logic      host_open;

    assign host_open = (state == INIT_DONE);

    always_comb begin
        state_next = state;
        issue_wr   = 1'b0;
        issue_rd   = 1'b0;
        next_addr  = REG_REV;
        next_wdata = '0;
        case (state)
            INIT_WR_CMD: begin
                next_addr  = REG_COMMAND;
                next_wdata = INIT_COMMAND;
                issue_wr   = cmd.rdy;
                if (cmd.rdy) state_next = INIT_WR_MAC0;
            end
            INIT_WR_MAC0: begin
                next_addr  = REG_MAC_0;
                next_wdata = INIT_STATION_ADDR[31:0];
                issue_wr   = cmd.rdy;
                if (cmd.rdy) state_next = INIT_WR_MAC1;
            end
            INIT_WR_MAC1: begin
                next_addr  = REG_MAC_1;
                next_wdata = {16'h0000, INIT_STATION_ADDR[47:32]};
                issue_wr   = cmd.rdy;
                if (cmd.rdy) state_next = INIT_WR_LEN;
            end
            INIT_WR_LEN: begin
                next_addr  = REG_FRM_LENGTH;
                next_wdata = cfg_data_t'(INIT_FRAME_LEN);
                issue_wr   = cmd.rdy;
                if (cmd.rdy) state_next = INIT_RD_REV;
            end
            INIT_RD_REV: begin
                issue_rd = cmd.rdy;  // next_addr already points at REG_REV.
                if (cmd.rdy) state_next = INIT_WAIT;
            end
            INIT_WAIT: begin
                if (cmd.rdata_vld) begin
                    state_next = (cmd.rdata == MAC_REV) ? INIT_DONE : INIT_FAIL;
                end
            end
            default: ;  // done and fail are terminal.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= INIT_WR_CMD;
            boot_wr <= 1'b0;
            boot_rd <= 1'b0;
        end else begin
            state   <= state_next;
            boot_wr <= issue_wr;
            boot_rd <= issue_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_wr || issue_rd) begin
            boot_addr  <= next_addr;
            boot_wdata <= next_wdata;
        end
    end

    // host owns the bridge only after a good boot.
    assign cmd.wr    = host_open ? host_wr    : boot_wr;
    assign cmd.rd    = host_open ? host_rd    : boot_rd;
    assign cmd.addr  = host_open ? host_addr  : boot_addr;
    assign cmd.wdata = host_open ? host_wdata : boot_wdata;

    assign host_rdy       = host_open && cmd.rdy;
    assign host_rdata     = cmd.rdata;
    assign host_rdata_vld = host_open && cmd.rdata_vld;

    assign init_done  = (state == INIT_DONE);
    assign init_error = (state == INIT_FAIL);

endmodule

/* mac_cfg/mac_cfg_if.sv */
module mac_cfg_if (
    input  logic          clk,
    input  logic          rst_n,
    mac_cfg_cmd_if.bridge cmd,
    mac_cfg_bus_if.master bus
);

    logic mac_wait_ff;
    logic finish;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_wait_ff <= 1'b0;
        end else begin
            mac_wait_ff <= bus.mac_wait;
        end
    end

    // access ends on the falling edge of wait.
    assign finish = mac_wait_ff && !bus.mac_wait;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.mac_wr <= 1'b0;
        end else if (cmd.wr) begin
            bus.mac_wr <= 1'b1;
        end else if (finish) begin
            bus.mac_wr <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.mac_rd <= 1'b0;
        end else if (cmd.rd) begin
            bus.mac_rd <= 1'b1;
        end else if (finish) begin
            bus.mac_rd <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.wr || cmd.rd) begin
            bus.mac_addr <= cmd.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.wr) begin
            bus.mac_wdata <= cmd.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (finish && bus.mac_rd) begin
            cmd.rdata <= bus.mac_rdata;  // slave data is valid while wait is low.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd.rdata_vld <= 1'b0;
        end else begin
            cmd.rdata_vld <= finish && bus.mac_rd;
        end
    end

    // busy from the request pulse until the strobe has dropped.
    always_comb begin
        if (cmd.wr || cmd.rd || bus.mac_wr || bus.mac_rd) begin
            cmd.rdy = 1'b0;
        end else begin
            cmd.rdy = 1'b1;
        end
    end

endmodule

/* common/mac_cfg_bus_if.sv */
interface mac_cfg_bus_if import mac_cfg_pkg::*; ();

    cfg_addr_t mac_addr;
    logic      mac_rd;     // held until wait falls.
    logic      mac_wr;     // held until wait falls.
    cfg_data_t mac_wdata;
    cfg_data_t mac_rdata;
    logic      mac_wait;

    modport master (
        output mac_addr,
        output mac_rd,
        output mac_wr,
        output mac_wdata,
        input  mac_rdata,
        input  mac_wait
    );

    modport slave (
        input  mac_addr,
        input  mac_rd,
        input  mac_wr,
        input  mac_wdata,
        output mac_rdata,
        output mac_wait
    );

endinterface

/* common/mac_cfg_cmd_if.sv */
interface mac_cfg_cmd_if import mac_cfg_pkg::*; ();

    logic      wr;         // one cycle pulse.
    logic      rd;         // one cycle pulse.
    cfg_addr_t addr;
    cfg_data_t wdata;
    logic      rdy;
    cfg_data_t rdata;
    logic      rdata_vld;  // one cycle pulse with rdata.

    modport requester (
        output wr,
        output rd,
        output addr,
        output wdata,
        input  rdy,
        input  rdata,
        input  rdata_vld
    );

    modport bridge (
        input  wr,
        input  rd,
        input  addr,
        input  wdata,
        output rdy,
        output rdata,
        output rdata_vld
    );

endinterface

/* common/mac_cfg_pkg.sv */
package mac_cfg_pkg;

    typedef logic [ 7:0] cfg_addr_t;     // register word address.
    typedef logic [31:0] cfg_data_t;
    typedef logic [47:0] station_addr_t;
    typedef logic [15:0] frame_len_t;

    // register map.
    localparam cfg_addr_t REG_REV         = 8'h00;  // read only.
    localparam cfg_addr_t REG_COMMAND     = 8'h02;
    localparam cfg_addr_t REG_MAC_0       = 8'h03;  // station address bits 31:0.
    localparam cfg_addr_t REG_MAC_1       = 8'h04;  // station address bits 47:32.
    localparam cfg_addr_t REG_FRM_LENGTH  = 8'h05;
    localparam cfg_addr_t REG_PAUSE_QUANT = 8'h06;
    localparam cfg_addr_t REG_SCRATCH     = 8'h07;

    // command register fields.
    localparam int CMD_TX_ENA_BIT  = 0;
    localparam int CMD_RX_ENA_BIT  = 1;
    localparam int CMD_PROMISC_BIT = 4;

    localparam cfg_data_t MAC_REV = 32'h0000_0901;

    // boot defaults.
    localparam cfg_data_t     INIT_COMMAND      = 32'h0000_0003;  // tx and rx on.
    localparam station_addr_t INIT_STATION_ADDR = 48'h00_1c_23_17_4a_cb;
    localparam frame_len_t    INIT_FRAME_LEN    = 16'd1518;

    // slave wait states per access.
    localparam int CSR_WAIT  = 3;
    localparam int CSR_CNT_W = $clog2(CSR_WAIT + 1);

    typedef enum logic [1:0] {
        CSR_IDLE,
        CSR_BUSY,
        CSR_DONE,
        CSR_HOLD
    } csr_state_t;

    typedef enum logic [2:0] {
        INIT_WR_CMD,
        INIT_WR_MAC0,
        INIT_WR_MAC1,
        INIT_WR_LEN,
        INIT_RD_REV,
        INIT_WAIT,
        INIT_DONE,
        INIT_FAIL
    } init_state_t;

endpackage
